// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0 -Wno-fatal
TOP       := motorDriveTb
FILELIST  := sources.f
OBJDIR    := obj_dir
LOG       := sim.log
FAILMSG   := Done: errors found

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/motorDriveChecks.sv ====
`timescale 1ns/100ps
`include "motor_config.svh"

module motorDriveChecks (
    input  logic                clk,
    input  logic                reset,
    input  busPkg::wbReq_t      wbReq,
    input  busPkg::wbRsp_t      wbRsp,
    input  motorPkg::gatePair_t pins [3],
    input  logic                noHighExpected,
    input  logic                pinsOffExpected,
    output int                  assertFails
);

    int   failCount = 0;
    logic anyHigh;
    logic anyPin;

    assign anyHigh     = pins[0].hi || pins[1].hi || pins[2].hi;
    assign anyPin      = anyHigh || pins[0].lo || pins[1].lo || pins[2].lo;
    assign assertFails = failCount;

    // ======================================================================
    // wishbone handshake
    // ======================================================================
    ackOneClock: assert property (
        @(posedge clk) disable iff (reset) wbRsp.ack |=> !wbRsp.ack
    ) else begin
        failCount++;
        $display("assertion: ack stayed high for more than one clock at %0t", $time);
    end

    ackAfterRequest: assert property (
        @(posedge clk) disable iff (reset) $rose(wbReq.cyc && wbReq.stb) |=> wbRsp.ack
    ) else begin
        failCount++;
        $display("assertion: ack did not follow the request by one clock at %0t", $time);
    end

    ackNeedsRequest: assert property (
        @(posedge clk) disable iff (reset) wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb)
    ) else begin
        failCount++;
        $display("assertion: ack came without a request at %0t", $time);
    end

    // ======================================================================
    // bridge pins
    // ======================================================================
    for (genvar leg = 0; leg < 3; leg++) begin : g_leg
        neverBothOn: assert property (
            @(posedge clk) disable iff (reset) !(pins[leg].hi && pins[leg].lo)
        ) else begin
            failCount++;
            $display("assertion: leg %0d has both switches on at %0t", leg, $time);
        end

        deadAfterHi: assert property (
            @(posedge clk) disable iff (reset)
                $fell(pins[leg].hi) |-> !pins[leg].lo [*`MOTOR_DEAD_CYCLES]
        ) else begin
            failCount++;
            $display("assertion: leg %0d low side came on too soon at %0t", leg, $time);
        end

        deadAfterLo: assert property (
            @(posedge clk) disable iff (reset)
                $fell(pins[leg].lo) |-> !pins[leg].hi [*`MOTOR_DEAD_CYCLES]
        ) else begin
            failCount++;
            $display("assertion: leg %0d high side came on too soon at %0t", leg, $time);
        end
    end

    noHighWhenDutyZero: assert property (
        @(posedge clk) disable iff (reset) noHighExpected |-> !anyHigh
    ) else begin
        failCount++;
        $display("assertion: a high-side pin is on with zero duty at %0t", $time);
    end

    pinsOffWhenStopped: assert property (
        @(posedge clk) disable iff (reset) pinsOffExpected |-> !anyPin
    ) else begin
        failCount++;
        $display("assertion: a bridge pin is on after the motor stopped at %0t", $time);
    end

endmodule

// ==== dv/motorDriveTb.sv ====
`timescale 1ns/100ps
`include "motor_config.svh"

module motorDriveTb;

    localparam int CLK_PERIOD       = 100;
    localparam int DRIVE_DELAY      = 10;
    localparam int STEP_PERIOD      = 24;         // short period for the direction tests
    localparam int STEPS_CHECKED    = 12;         // two electrical turns
    localparam int FAST_STEP_PERIOD = 2;          // float step shorter than the dead time
    localparam int FAST_RUN_CLOCKS  = 48;         // four electrical turns
    localparam int PWM_PERIOD_MAX   = 400 + 255;
    localparam int ACK_WAIT_MAX     = 8;
    // each test gets twice its planned length, the margin covers bus traffic
    localparam int WATCHDOG_CLOCKS =
        2 * (STEP_PERIOD * (2 * STEPS_CHECKED + 3 + 5) + FAST_RUN_CLOCKS + PWM_PERIOD_MAX)
        + 1000;

    logic                clk;
    logic                reset;
    busPkg::wbReq_t      wbReq;
    busPkg::wbRsp_t      wbRsp;
    logic                aH, aL, bH, bL, cH, cL;
    motorPkg::gatePair_t pinPairs [3];
    logic                noHighExpected;
    logic                pinsOffExpected;
    int                  assertFails;
    int                  valueErrors = 0;
    int                  testsPassed = 0;
    int                  testsFailed = 0;
    int                  testErrorsAtStart;
    logic [31:0]         lcgState = 32'd62580;

    assign pinPairs[0] = '{hi: aH, lo: aL};
    assign pinPairs[1] = '{hi: bH, lo: bL};
    assign pinPairs[2] = '{hi: cH, lo: cL};

    motorDriveTop i_motorDriveTop (
        .clk   (clk),
        .reset (reset),
        .wbReq (wbReq),
        .wbRsp (wbRsp),
        .aH    (aH),
        .aL    (aL),
        .bH    (bH),
        .bL    (bL),
        .cH    (cH),
        .cL    (cL)
    );

    motorDriveChecks i_motorDriveChecks (
        .clk             (clk),
        .reset           (reset),
        .wbReq           (wbReq),
        .wbRsp           (wbRsp),
        .pins            (pinPairs),
        .noHighExpected  (noHighExpected),
        .pinsOffExpected (pinsOffExpected),
        .assertFails     (assertFails)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CLOCKS) @(posedge clk);
        $display("watchdog expired after %0d clocks, the tests did not finish", WATCHDOG_CLOCKS);
        $display("Done: errors found");
        $finish;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 8;  // low bits of an LCG repeat quickly
    endfunction

    function automatic int errorTotal();
        return valueErrors + assertFails;
    endfunction

    // low-side pins {aL, bL, cL} expected in each step of the six-step table
    function automatic logic [2:0] lowSidePattern(input logic [2:0] step);
        case (step)
            3'd0, 3'd5: return 3'b010;
            3'd1, 3'd2: return 3'b001;
            3'd3, 3'd4: return 3'b100;
            default:    return 3'b000;
        endcase
    endfunction

    task automatic waitClocks(input int count);
        repeat (count) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic checkValue(input string name, input busPkg::data_t expected,
                              input busPkg::data_t actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic busAccess(input logic write, input busPkg::addr_t adr,
                             input busPkg::data_t wrData, output busPkg::data_t rdValue);
        int waited;
        wbReq  = '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat: wrData};
        waited = 0;
        do begin
            waitClocks(1);
            waited++;
        end while (!wbRsp.ack && waited < ACK_WAIT_MAX);
        rdValue = wbRsp.dat;
        if (!wbRsp.ack) begin
            $display("no ack from the register file within %0d clocks", ACK_WAIT_MAX);
            valueErrors++;
        end else begin
            checkValue("ackLatency", 32'd1, busPkg::data_t'(waited));
        end
        wbReq = '0;
        waitClocks(1);  // ack is low again before the next request
    endtask

    task automatic busWrite(input busPkg::addr_t adr, input busPkg::data_t data);
        busPkg::data_t ignored;
        busAccess(1'b1, adr, data, ignored);
    endtask

    task automatic busRead(input busPkg::addr_t adr, output busPkg::data_t data);
        busAccess(1'b0, adr, '0, data);
    endtask

    task automatic stopMotor();
        busWrite(busPkg::ADDR_CONTROL, '0);
        waitClocks(2);
    endtask

    task automatic beginTest();
        testErrorsAtStart = errorTotal();
    endtask

    task automatic endTest(input string name);
        if (errorTotal() == testErrorsAtStart) begin
            testsPassed++;
            $display("test %s passed", name);
        end else begin
            testsFailed++;
            $display("test %s failed", name);
        end
    endtask

    // samples every step in its middle, each loop pass lasts exactly one period
    task automatic runSteps(input string name, input logic reverse);
        busPkg::data_t status;
        logic [2:0]    expected;
        busWrite(busPkg::ADDR_PERIOD, busPkg::data_t'(STEP_PERIOD));
        busRead(busPkg::ADDR_STATUS, status);
        expected = status[2:0];
        busWrite(busPkg::ADDR_CONTROL, {30'd0, reverse, 1'b1});
        waitClocks(STEP_PERIOD / 2);
        for (int i = 0; i < STEPS_CHECKED; i++) begin
            checkValue({name, "LowSide"}, busPkg::data_t'(lowSidePattern(expected)),
                       busPkg::data_t'({aL, bL, cL}));
            busRead(busPkg::ADDR_STATUS, status);
            checkValue({name, "StepIndex"}, busPkg::data_t'(expected),
                       busPkg::data_t'(status[2:0]));
            if (reverse) begin
                expected = (expected == 3'd0) ? 3'd5 : expected - 3'd1;
            end else begin
                expected = (expected == 3'd5) ? 3'd0 : expected + 3'd1;
            end
            waitClocks(STEP_PERIOD - 2);
        end
        stopMotor();
    endtask

    initial begin
        busPkg::data_t period;
        busPkg::data_t duty;
        busPkg::data_t status;
        logic [2:0]    held;
        int            highCount;
        int            diff;

        wbReq           = '0;
        noHighExpected  = 1'b0;
        pinsOffExpected = 1'b0;
        reset           = 1'b1;
        waitClocks(5);
        reset = 1'b0;

        beginTest();
        checkValue("resetPins", '0, busPkg::data_t'({aH, aL, bH, bL, cH, cL}));
        checkValue("resetAck", '0, busPkg::data_t'(wbRsp.ack));
        busRead(busPkg::ADDR_STATUS, status);
        checkValue("resetStatus", '0, status);
        endTest("afterReset");

        beginTest();
        for (int i = 0; i < 4; i++) begin
            period = nextRandom() & 32'h0000_FFFF;
            duty   = nextRandom() & 32'h0000_00FF;
            busWrite(busPkg::ADDR_PERIOD, period);
            busWrite(busPkg::ADDR_DUTY, duty);
            busRead(busPkg::ADDR_PERIOD, status);
            checkValue("periodReadback", period, status);
            busRead(busPkg::ADDR_DUTY, status);
            checkValue("dutyReadback", duty, status);
        end
        endTest("registerAccess");

        beginTest();
        runSteps("forward", 1'b0);
        endTest("forwardCommutation");

        beginTest();
        runSteps("reverse", 1'b1);
        endTest("reverseCommutation");

        // ==================================================================
        // dead time and PWM
        // ==================================================================
        beginTest();
        busWrite(busPkg::ADDR_DUTY, '0);
        noHighExpected = 1'b1;
        busWrite(busPkg::ADDR_PERIOD, busPkg::data_t'(STEP_PERIOD));
        busWrite(busPkg::ADDR_CONTROL, 32'd1);
        waitClocks(3 * STEP_PERIOD);
        stopMotor();
        noHighExpected = 1'b0;
        // with two-clock steps only the dead-time counters keep H and L apart
        busWrite(busPkg::ADDR_DUTY, busPkg::data_t'((1 << `MOTOR_PWM_BITS) - 1));
        busWrite(busPkg::ADDR_PERIOD, busPkg::data_t'(FAST_STEP_PERIOD));
        busWrite(busPkg::ADDR_CONTROL, 32'd1);
        waitClocks(FAST_RUN_CLOCKS);
        stopMotor();
        duty   = nextRandom() & 32'h0000_00FF;
        period = 32'd400 + (nextRandom() & 32'h0000_00FF);  // one step outlasts the window
        busWrite(busPkg::ADDR_DUTY, duty);
        busWrite(busPkg::ADDR_PERIOD, period);
        busWrite(busPkg::ADDR_CONTROL, 32'd1);
        waitClocks(20);
        highCount = 0;
        repeat (1 << `MOTOR_PWM_BITS) begin
            if (aH || bH || cH) begin
                highCount++;
            end
            waitClocks(1);
        end
        stopMotor();
        diff = highCount - int'(duty);
        assert (diff <= `MOTOR_DEAD_CYCLES && diff >= -`MOTOR_DEAD_CYCLES) else begin
            $display("FAIL pwmOnTime expected %0d actual %0d", duty, highCount);
            valueErrors++;
        end
        endTest("deadTimeAndPwm");

        beginTest();
        busWrite(busPkg::ADDR_PERIOD, busPkg::data_t'(STEP_PERIOD));
        busWrite(busPkg::ADDR_CONTROL, 32'd1);
        waitClocks(2 * STEP_PERIOD + 5);
        busWrite(busPkg::ADDR_CONTROL, '0);
        waitClocks(1);  // now two clocks past the ack
        checkValue("stopPins", '0, busPkg::data_t'({aH, aL, bH, bL, cH, cL}));
        pinsOffExpected = 1'b1;
        busRead(busPkg::ADDR_STATUS, status);
        held = status[2:0];
        waitClocks(3 * STEP_PERIOD);
        busRead(busPkg::ADDR_STATUS, status);
        checkValue("stopStepHeld", busPkg::data_t'(held), busPkg::data_t'(status[2:0]));
        checkValue("stopRunning", '0, busPkg::data_t'(status[5]));
        pinsOffExpected = 1'b0;
        endTest("stop");

        $display("tests passed %0d, failed %0d, value errors %0d, assertion failures %0d",
                 testsPassed, testsFailed, valueErrors, assertFails);
        if (errorTotal() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== include/motor_config.svh ====
`ifndef MOTOR_CONFIG_SVH
`define MOTOR_CONFIG_SVH

// ======================================================================
// power stage
// ======================================================================
`define MOTOR_PWM_BITS        8      // carrier period is 2**MOTOR_PWM_BITS clocks
`define MOTOR_PERIOD_BITS     16
`define MOTOR_DEAD_CYCLES     4      // both switches off between leg transitions

`define MOTOR_DEFAULT_PERIOD  1000
`define MOTOR_DEFAULT_DUTY    128    // half duty out of reset

// ======================================================================
// host bus
// ======================================================================
`define BUS_ADDR_BITS         4      // word addresses
`define BUS_DATA_BITS         32

`endif

// ==== sources.f ====
+incdir+include
verilog/motorPkg.sv
verilog/busPkg.sv
verilog/motorRegs.sv
verilog/commutationSequencer.sv
verilog/phaseLeg.sv
verilog/bridgeGuard.sv
verilog/motorDriveTop.sv
dv/motorDriveChecks.sv
dv/motorDriveTb.sv

// ==== verilog/bridgeGuard.sv ====
`timescale 1ns/100ps

module bridgeGuard (
    input  logic                 clk,
    input  logic                 reset,
    input  motorPkg::motorCtrl_t ctrl,
    input  motorPkg::gatePair_t  gates [3],
    output logic                 aH,
    output logic                 aL,
    output logic                 bH,
    output logic                 bL,
    output logic                 cH,
    output logic                 cL,
    output logic                 fault
);

    logic shootThrough;
    logic blank;

    always_comb begin
        shootThrough = 1'b0;
        for (int leg = 0; leg < 3; leg++) begin
            shootThrough = shootThrough | (gates[leg].hi & gates[leg].lo);
        end
    end

    // a new shoot-through wins over a clear in the same clock
    always_ff @(posedge clk) begin
        if (reset) begin
            fault <= 1'b0;
        end else if (shootThrough) begin
            fault <= 1'b1;
        end else if (ctrl.clearFault) begin
            fault <= 1'b0;
        end
    end

    assign blank = fault || shootThrough;  // offending clock is blanked too

    // ======================================================================
    // bridge pins
    // ======================================================================
    assign aH = gates[0].hi && !blank;
    assign aL = gates[0].lo && !blank;
    assign bH = gates[1].hi && !blank;
    assign bL = gates[1].lo && !blank;
    assign cH = gates[2].hi && !blank;
    assign cL = gates[2].lo && !blank;

endmodule

// ==== verilog/busPkg.sv ====
`include "motor_config.svh"

package busPkg;

    typedef logic [`BUS_ADDR_BITS-1:0] addr_t;
    typedef logic [`BUS_DATA_BITS-1:0] data_t;

    // wishbone classic, master side
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat;
    } wbReq_t;

    // wishbone classic, slave side
    typedef struct packed {
        logic  ack;
        data_t dat;
    } wbRsp_t;

    localparam addr_t ADDR_CONTROL = 'd0;
    localparam addr_t ADDR_PERIOD  = 'd1;
    localparam addr_t ADDR_DUTY    = 'd2;
    localparam addr_t ADDR_STATUS  = 'd3;  // read only

endpackage

// ==== verilog/commutationSequencer.sv ====
`timescale 1ns/100ps
`include "motor_config.svh"

module commutationSequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  motorPkg::motorCtrl_t ctrl,
    output motorPkg::legCmd_t    legCmd [3],
    output logic [2:0]           stepIndex,
    output logic                 running
);

    localparam motorPkg::stepIndex_t STEP_LAST =
        motorPkg::stepIndex_t'(motorPkg::STEP_COUNT - 1);

    motorPkg::period_t    periodCnt;
    motorPkg::duty_t      pwmCnt;
    logic                 stepTick;
    motorPkg::stepIndex_t stepNext;
    motorPkg::legMode_t   stepModes [3];

    // last clock of the step period, a period of 0 or 1 steps every clock
    assign stepTick = ctrl.run && ({1'b0, periodCnt} + 1'b1 >= {1'b0, ctrl.period});

    always_comb begin
        stepNext = stepIndex;
        if (stepTick) begin
            if (ctrl.reverse) begin
                stepNext = (stepIndex == '0) ? STEP_LAST : stepIndex - 1'b1;
            end else begin
                stepNext = (stepIndex == STEP_LAST) ? '0 : stepIndex + 1'b1;
            end
        end
    end

    // ======================================================================
    // six-step table, legs in the order A, B, C
    // ======================================================================
    always_comb begin
        case (stepNext)
            3'd0:    stepModes = '{motorPkg::HIGH,  motorPkg::LOW,   motorPkg::FLOAT};
            3'd1:    stepModes = '{motorPkg::HIGH,  motorPkg::FLOAT, motorPkg::LOW};
            3'd2:    stepModes = '{motorPkg::FLOAT, motorPkg::HIGH,  motorPkg::LOW};
            3'd3:    stepModes = '{motorPkg::LOW,   motorPkg::HIGH,  motorPkg::FLOAT};
            3'd4:    stepModes = '{motorPkg::LOW,   motorPkg::FLOAT, motorPkg::HIGH};
            3'd5:    stepModes = '{motorPkg::FLOAT, motorPkg::LOW,   motorPkg::HIGH};
            default: stepModes = '{motorPkg::FLOAT, motorPkg::FLOAT, motorPkg::FLOAT};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            periodCnt <= '0;
            pwmCnt    <= '0;
            stepIndex <= '0;
            running   <= 1'b0;
            for (int leg = 0; leg < 3; leg++) begin
                legCmd[leg] <= '{mode: motorPkg::FLOAT, pwmOn: 1'b0};
            end
        end else begin
            pwmCnt    <= pwmCnt + 1'b1;  // carrier never stops
            stepIndex <= stepNext;
            running   <= ctrl.run;
            if (!ctrl.run || stepTick) begin
                periodCnt <= '0;
            end else begin
                periodCnt <= periodCnt + 1'b1;
            end
            for (int leg = 0; leg < 3; leg++) begin
                legCmd[leg].mode  <= ctrl.run ? stepModes[leg] : motorPkg::FLOAT;
                legCmd[leg].pwmOn <= pwmCnt < ctrl.duty;  // duty 0 never turns on
            end
        end
    end

    stepInRange: assert property (
        @(posedge clk) disable iff (reset) stepIndex <= STEP_LAST
    );

endmodule

// ==== verilog/motorDriveTop.sv ====
`timescale 1ns/100ps
`include "motor_config.svh"

module motorDriveTop (
    input  logic           clk,
    input  logic           reset,
    input  busPkg::wbReq_t wbReq,
    output busPkg::wbRsp_t wbRsp,
    output logic           aH,
    output logic           aL,
    output logic           bH,
    output logic           bL,
    output logic           cH,
    output logic           cL
);

    motorPkg::motorCtrl_t   ctrl;
    motorPkg::motorStatus_t status;
    motorPkg::legCmd_t      legCmd [3];
    motorPkg::gatePair_t    gates [3];
    logic [2:0]             stepIndex;
    logic                   running;
    logic                   fault;

    assign status = '{stepIndex: stepIndex, fault: fault, running: running};

    motorRegs i_motorRegs (
        .clk    (clk),
        .reset  (reset),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .status (status),
        .ctrl   (ctrl)
    );

    commutationSequencer i_commutationSequencer (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .legCmd    (legCmd),
        .stepIndex (stepIndex),
        .running   (running)
    );

    // legs A, B, C
    for (genvar leg = 0; leg < 3; leg++) begin : g_leg
        phaseLeg #(
            .DEAD_CYCLES (`MOTOR_DEAD_CYCLES)
        ) i_phaseLeg (
            .clk   (clk),
            .reset (reset),
            .cmd   (legCmd[leg]),
            .gate  (gates[leg])
        );
    end

    bridgeGuard i_bridgeGuard (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl),
        .gates (gates),
        .aH    (aH),
        .aL    (aL),
        .bH    (bH),
        .bL    (bL),
        .cH    (cH),
        .cL    (cL),
        .fault (fault)
    );

endmodule

// ==== verilog/motorPkg.sv ====
`include "motor_config.svh"

package motorPkg;

    localparam int unsigned STEP_COUNT = 6;

    typedef logic [2:0]                    stepIndex_t;
    typedef logic [`MOTOR_PERIOD_BITS-1:0] period_t;
    typedef logic [`MOTOR_PWM_BITS-1:0]    duty_t;

    typedef enum logic [1:0] {
        FLOAT = 2'd0,  // both switches off
        LOW   = 2'd1,  // low side held on
        HIGH  = 2'd2   // high side chopped by the carrier
    } legMode_t;

    typedef struct packed {
        legMode_t mode;
        logic     pwmOn;
    } legCmd_t;

    typedef struct packed {
        logic hi;
        logic lo;
    } gatePair_t;

    typedef struct packed {
        logic    run;
        logic    reverse;
        logic    clearFault;  // single clock pulse
        period_t period;
        duty_t   duty;
    } motorCtrl_t;

    typedef struct packed {
        stepIndex_t stepIndex;
        logic       fault;
        logic       running;
    } motorStatus_t;

endpackage

// ==== verilog/motorRegs.sv ====
`timescale 1ns/100ps
`include "motor_config.svh"

module motorRegs (
    input  logic                   clk,
    input  logic                   reset,
    input  busPkg::wbReq_t         wbReq,
    output busPkg::wbRsp_t         wbRsp,
    input  motorPkg::motorStatus_t status,
    output motorPkg::motorCtrl_t   ctrl
);

    logic                reqNew;
    logic                wrEn;
    busPkg::data_t       rdData;

    assign reqNew = wbReq.cyc && wbReq.stb && !wbRsp.ack;  // first clock of a request
    assign wrEn   = reqNew && wbReq.we;

    always_comb begin
        rdData = '0;
        case (wbReq.adr)
            busPkg::ADDR_CONTROL: rdData[1:0] = {ctrl.reverse, ctrl.run};
            busPkg::ADDR_PERIOD:  rdData[`MOTOR_PERIOD_BITS-1:0] = ctrl.period;
            busPkg::ADDR_DUTY:    rdData[`MOTOR_PWM_BITS-1:0] = ctrl.duty;
            busPkg::ADDR_STATUS: begin
                rdData[2:0] = status.stepIndex;
                rdData[4]   = status.fault;
                rdData[5]   = status.running;
            end
            default:              rdData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbRsp.ack <= 1'b0;
        end else begin
            wbRsp.ack <= reqNew;  // drops for a clock before the next request
        end
        if (reqNew) begin
            wbRsp.dat <= rdData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.run        <= 1'b0;
            ctrl.reverse    <= 1'b0;
            ctrl.clearFault <= 1'b0;
            ctrl.period     <= motorPkg::period_t'(`MOTOR_DEFAULT_PERIOD);
            ctrl.duty       <= motorPkg::duty_t'(`MOTOR_DEFAULT_DUTY);
        end else begin
            ctrl.clearFault <= 1'b0;
            if (wrEn) begin
                case (wbReq.adr)
                    busPkg::ADDR_CONTROL: begin
                        ctrl.run        <= wbReq.dat[0];
                        ctrl.reverse    <= wbReq.dat[1];
                        ctrl.clearFault <= wbReq.dat[2];  // gone again next clock
                    end
                    busPkg::ADDR_PERIOD: ctrl.period <= wbReq.dat[`MOTOR_PERIOD_BITS-1:0];
                    busPkg::ADDR_DUTY:   ctrl.duty <= wbReq.dat[`MOTOR_PWM_BITS-1:0];
                    default: begin
                    end
                endcase
            end
        end
    end

    // ======================================================================
    // bus protocol
    // ======================================================================
    ackOnePulse: assert property (
        @(posedge clk) disable iff (reset) wbRsp.ack |=> !wbRsp.ack
    );

endmodule

// ==== verilog/phaseLeg.sv ====
`timescale 1ns/100ps
`include "motor_config.svh"

module phaseLeg #(
    parameter int DEAD_CYCLES = `MOTOR_DEAD_CYCLES
) (
    input  logic                clk,
    input  logic                reset,
    input  motorPkg::legCmd_t   cmd,
    output motorPkg::gatePair_t gate
);

    localparam int CNT_BITS = $clog2(DEAD_CYCLES + 1);
    localparam logic [CNT_BITS-1:0] DEAD_LAST = CNT_BITS'(DEAD_CYCLES - 1);

    logic                wantHi;
    logic                wantLo;
    logic [CNT_BITS-1:0] hiOffCnt;  // clocks the high side has been off
    logic [CNT_BITS-1:0] loOffCnt;

    function automatic logic [CNT_BITS-1:0] nextOffCnt(
        input logic                on,
        input logic [CNT_BITS-1:0] cnt
    );
        if (on) begin
            return '0;
        end
        return (cnt >= DEAD_LAST) ? DEAD_LAST : cnt + 1'b1;
    endfunction

    assign wantHi = (cmd.mode == motorPkg::HIGH) && cmd.pwmOn;
    assign wantLo = (cmd.mode == motorPkg::LOW);

    always_ff @(posedge clk) begin
        if (reset) begin
            gate     <= '0;
            hiOffCnt <= '0;
            loOffCnt <= '0;
        end else begin
            hiOffCnt <= nextOffCnt(gate.hi, hiOffCnt);
            loOffCnt <= nextOffCnt(gate.lo, loOffCnt);
            // a switch stays on while wanted, it turns on once the other side is dead
            gate.hi <= wantHi && !gate.lo && (gate.hi || loOffCnt >= DEAD_LAST);
            gate.lo <= wantLo && !gate.hi && (gate.lo || hiOffCnt >= DEAD_LAST);
        end
    end

    neverBothOn: assert property (
        @(posedge clk) disable iff (reset) !(gate.hi && gate.lo)
    );

    deadAfterHi: assert property (
        @(posedge clk) disable iff (reset) $fell(gate.hi) |-> !gate.lo [*DEAD_CYCLES]
    );

    deadAfterLo: assert property (
        @(posedge clk) disable iff (reset) $fell(gate.lo) |-> !gate.hi [*DEAD_CYCLES]
    );

endmodule
